// ==== axi_mem_pkg.sv ====
// ------------------------------------------------------------
// Shared widths, vector types and FSM state encodings for
// the AXI4 to single-port SRAM bridge
// ------------------------------------------------------------
`default_nettype none

package axi_mem_pkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int ID_W       = 4;
    localparam int LEN_W      = 8;

    // SRAM word address, 8K words
    localparam int MEM_ADDR_W = 13;

    // Byte offset bits dropped from an AXI address
    localparam int WORD_LSB   = 2;

    // ------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------
    typedef logic [ADDR_W-1:0]     axi_addr_t;
    typedef logic [DATA_W-1:0]     axi_data_t;
    typedef logic [STRB_W-1:0]     axi_strb_t;
    typedef logic [ID_W-1:0]       axi_id_t;
    typedef logic [LEN_W-1:0]      axi_len_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // ------------------------------------------------------------
    // Engine FSM states
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_BURST,
        WR_RESP
    } wr_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ISSUE,
        RD_CAPTURE,
        RD_RESP
    } rd_state_t;

endpackage

`default_nettype wire

// ==== mem_req_if.sv ====
// ------------------------------------------------------------
// Memory request from one engine and its arbiter grant
// ------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface mem_req_if
    import axi_mem_pkg::*;
();

    // Level request, held until granted or withdrawn
    logic      req;
    logic      we;
    mem_addr_t addr;
    axi_data_t wdata;
    axi_strb_t be;

    // Combinational answer in the same cycle
    logic      gnt;

    modport engine (
        output req, we, addr, wdata, be,
        input  gnt
    );

    modport arbiter (
        input  req, we, addr, wdata, be,
        output gnt
    );

endinterface

`default_nettype wire

// ==== axi_write_engine.sv ====
// ------------------------------------------------------------
// Write engine: AW, W and B channels, with one memory write
// request per accepted W beat
// ------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axi_write_engine
    import axi_mem_pkg::*;
(
    input  logic      ACLK,
    input  logic      ARESETn,

    // Write address channel
    input  axi_id_t   aw_id_i,
    input  axi_addr_t aw_addr_i,
    input  axi_len_t  aw_len_i,
    input  logic      aw_valid_i,
    output logic      aw_ready_o,

    // Write data channel
    input  axi_data_t w_data_i,
    input  axi_strb_t w_strb_i,
    input  logic      w_valid_i,
    output logic      w_ready_o,

    // Write response channel
    output axi_id_t   b_id_o,
    output logic      b_valid_o,
    input  logic      b_ready_i,

    mem_req_if.engine mem
);

    wr_state_t state_q;
    axi_len_t  beats_left_q;
    axi_id_t   id_q;
    mem_addr_t addr_q;

    logic      aw_hs;
    logic      w_beat;
    logic      b_hs;

    assign aw_hs  = aw_valid_i & aw_ready_o;
    assign w_beat = mem.req & mem.gnt;
    assign b_hs   = b_valid_o & b_ready_i;

    // ------------------------------------------------------------
    // Channel handshakes
    // ------------------------------------------------------------
    assign aw_ready_o = (state_q == WR_IDLE);
    // A beat is taken only in the cycle the SRAM write happens
    assign w_ready_o  = mem.gnt;
    assign b_valid_o  = (state_q == WR_RESP);
    assign b_id_o     = id_q;

    // Memory request follows WVALID during the burst
    assign mem.req   = (state_q == WR_BURST) & w_valid_i;
    assign mem.we    = 1'b1;
    assign mem.addr  = addr_q;
    assign mem.wdata = w_data_i;
    assign mem.be    = w_strb_i;

    // ------------------------------------------------------------
    // Burst FSM
    // ------------------------------------------------------------
    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            state_q      <= WR_IDLE;
            beats_left_q <= '0;
        end
        else
        begin
            case (state_q)
                WR_IDLE:
                begin
                    if (aw_hs)
                    begin
                        state_q      <= WR_BURST;
                        beats_left_q <= aw_len_i;
                    end
                end
                WR_BURST:
                begin
                    // Burst length comes from AWLEN, not from WLAST
                    if (w_beat)
                    begin
                        if (beats_left_q == '0)
                            state_q <= WR_RESP;
                        else
                            beats_left_q <= beats_left_q - axi_len_t'(1);
                    end
                end
                WR_RESP:
                begin
                    if (b_hs)
                        state_q <= WR_IDLE;
                end
                default:
                    state_q <= WR_IDLE;
            endcase
        end
    end

    // Transaction ID and running word address
    always_ff @(posedge ACLK)
    begin
        if (aw_hs)
        begin
            id_q   <= aw_id_i;
            addr_q <= aw_addr_i[WORD_LSB +: MEM_ADDR_W];
        end
        else if (w_beat)
        begin
            addr_q <= addr_q + mem_addr_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== axi_read_engine.sv ====
// ------------------------------------------------------------
// Read engine: AR and R channels, one SRAM read per beat and
// capture of the returned word into the R output register
// ------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axi_read_engine
    import axi_mem_pkg::*;
(
    input  logic      ACLK,
    input  logic      ARESETn,

    // Read address channel
    input  axi_id_t   ar_id_i,
    input  axi_addr_t ar_addr_i,
    input  axi_len_t  ar_len_i,
    input  logic      ar_valid_i,
    output logic      ar_ready_o,

    // Read data channel
    output axi_id_t   r_id_o,
    output axi_data_t r_data_o,
    output logic      r_last_o,
    output logic      r_valid_o,
    input  logic      r_ready_i,

    // SRAM read data, one cycle after the access
    input  axi_data_t q_i,

    mem_req_if.engine mem
);

    rd_state_t state_q;
    axi_len_t  beats_left_q;
    axi_id_t   id_q;
    mem_addr_t addr_q;

    logic      ar_hs;
    logic      rd_issued;
    logic      r_hs;

    assign ar_hs     = ar_valid_i & ar_ready_o;
    assign rd_issued = mem.req & mem.gnt;
    assign r_hs      = r_valid_o & r_ready_i;

    // ------------------------------------------------------------
    // Channel outputs
    // ------------------------------------------------------------
    assign ar_ready_o = (state_q == RD_IDLE);
    assign r_valid_o  = (state_q == RD_RESP);
    assign r_id_o     = id_q;
    // Counter only moves on the R handshake, so LAST holds under stall
    assign r_last_o   = (beats_left_q == '0);

    // Full-word read request while issuing
    assign mem.req   = (state_q == RD_ISSUE);
    assign mem.we    = 1'b0;
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;
    assign mem.be    = '1;

    // ------------------------------------------------------------
    // Beat FSM, one read in flight at a time
    // ------------------------------------------------------------
    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            state_q      <= RD_IDLE;
            beats_left_q <= '0;
        end
        else
        begin
            case (state_q)
                RD_IDLE:
                begin
                    if (ar_hs)
                    begin
                        state_q      <= RD_ISSUE;
                        beats_left_q <= ar_len_i;
                    end
                end
                RD_ISSUE:
                begin
                    if (rd_issued)
                        state_q <= RD_CAPTURE;
                end
                // SRAM output is valid during this cycle
                RD_CAPTURE:
                    state_q <= RD_RESP;
                RD_RESP:
                begin
                    if (r_hs)
                    begin
                        if (beats_left_q == '0)
                        begin
                            state_q <= RD_IDLE;
                        end
                        else
                        begin
                            state_q      <= RD_ISSUE;
                            beats_left_q <= beats_left_q - axi_len_t'(1);
                        end
                    end
                end
                default:
                    state_q <= RD_IDLE;
            endcase
        end
    end

    // ID, word address and R data register
    always_ff @(posedge ACLK)
    begin
        if (ar_hs)
        begin
            id_q   <= ar_id_i;
            addr_q <= ar_addr_i[WORD_LSB +: MEM_ADDR_W];
        end
        else if (rd_issued)
        begin
            addr_q <= addr_q + mem_addr_t'(1);
        end

        if (state_q == RD_CAPTURE)
            r_data_o <= q_i;
    end

endmodule

`default_nettype wire

// ==== mem_port_arbiter.sv ====
// ------------------------------------------------------------
// Round-robin arbiter between write and read engines, and the
// multiplexer onto the single SRAM port
// ------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module mem_port_arbiter
    import axi_mem_pkg::*;
(
    input  logic       ACLK,
    input  logic       ARESETn,

    mem_req_if.arbiter wr,
    mem_req_if.arbiter rd,

    // SRAM port, CEN and WEN active low
    output logic       cen_o,
    output logic       wen_o,
    output mem_addr_t  a_o,
    output axi_data_t  d_o,
    output axi_strb_t  be_o
);

    // Low favours the write engine
    logic prefer_rd_q;
    logic gnt_wr;
    logic gnt_rd;

    always_comb
    begin
        gnt_wr = wr.req;
        gnt_rd = rd.req;
        // Contention is settled by the preference flag
        if (wr.req && rd.req)
        begin
            gnt_wr = !prefer_rd_q;
            gnt_rd = prefer_rd_q;
        end
    end

    assign wr.gnt = gnt_wr;
    assign rd.gnt = gnt_rd;

    // Port mux, SRAM idle when nobody is granted
    always_comb
    begin
        cen_o = 1'b1;
        wen_o = 1'b1;
        a_o   = wr.addr;
        d_o   = wr.wdata;
        be_o  = wr.be;
        if (gnt_rd)
        begin
            cen_o = 1'b0;
            wen_o = !rd.we;
            a_o   = rd.addr;
            d_o   = rd.wdata;
            be_o  = rd.be;
        end
        else if (gnt_wr)
        begin
            cen_o = 1'b0;
            wen_o = !wr.we;
        end
    end

    // Swap preference after each access
    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
            prefer_rd_q <= 1'b0;
        else if (!cen_o)
            prefer_rd_q <= !prefer_rd_q;
    end

endmodule

`default_nettype wire

// ==== axi_mem_bridge.sv ====
// ------------------------------------------------------------
// AXI4 slave to single-port SRAM bridge, top level
// ------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axi_mem_bridge
    import axi_mem_pkg::*;
(
    input  logic      ACLK,
    input  logic      ARESETn,

    // ------------------------------------------------------------
    // AXI4 slave port
    // ------------------------------------------------------------
    input  axi_id_t   aw_id_i,
    input  axi_addr_t aw_addr_i,
    input  axi_len_t  aw_len_i,
    input  logic      aw_valid_i,
    output logic      aw_ready_o,

    input  axi_data_t w_data_i,
    input  axi_strb_t w_strb_i,
    input  logic      w_last_i,
    input  logic      w_valid_i,
    output logic      w_ready_o,

    output axi_id_t   b_id_o,
    output logic      b_valid_o,
    input  logic      b_ready_i,

    input  axi_id_t   ar_id_i,
    input  axi_addr_t ar_addr_i,
    input  axi_len_t  ar_len_i,
    input  logic      ar_valid_i,
    output logic      ar_ready_o,

    output axi_id_t   r_id_o,
    output axi_data_t r_data_o,
    output logic      r_last_o,
    output logic      r_valid_o,
    input  logic      r_ready_i,

    // ------------------------------------------------------------
    // SRAM port
    // ------------------------------------------------------------
    output logic      cen_o,
    output logic      wen_o,
    output mem_addr_t a_o,
    output axi_data_t d_o,
    output axi_strb_t be_o,
    input  axi_data_t q_i
);

    // One request channel per engine
    mem_req_if wr_req ();
    mem_req_if rd_req ();

    axi_write_engine u_write_engine (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .aw_id_i    (aw_id_i),
        .aw_addr_i  (aw_addr_i),
        .aw_len_i   (aw_len_i),
        .aw_valid_i (aw_valid_i),
        .aw_ready_o (aw_ready_o),
        .w_data_i   (w_data_i),
        .w_strb_i   (w_strb_i),
        .w_valid_i  (w_valid_i),
        .w_ready_o  (w_ready_o),
        .b_id_o     (b_id_o),
        .b_valid_o  (b_valid_o),
        .b_ready_i  (b_ready_i),
        .mem        (wr_req)
    );

    axi_read_engine u_read_engine (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .ar_id_i    (ar_id_i),
        .ar_addr_i  (ar_addr_i),
        .ar_len_i   (ar_len_i),
        .ar_valid_i (ar_valid_i),
        .ar_ready_o (ar_ready_o),
        .r_id_o     (r_id_o),
        .r_data_o   (r_data_o),
        .r_last_o   (r_last_o),
        .r_valid_o  (r_valid_o),
        .r_ready_i  (r_ready_i),
        .q_i        (q_i),
        .mem        (rd_req)
    );

    // WLAST is not needed by the engine, burst length comes from AWLEN
    mem_port_arbiter u_arbiter (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .wr      (wr_req),
        .rd      (rd_req),
        .cen_o   (cen_o),
        .wen_o   (wen_o),
        .a_o     (a_o),
        .d_o     (d_o),
        .be_o    (be_o)
    );

endmodule

`default_nettype wire

// ==== axi_mem_bridge_asserts.sv ====
// ------------------------------------------------------------
// Concurrent protocol assertions, bound into the bridge top
// ------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axi_mem_bridge_asserts
    import axi_mem_pkg::*;
(
    input logic      ACLK,
    input logic      ARESETn,
    input logic      w_valid_i,
    input logic      w_ready_o,
    input logic      w_last_i,
    input axi_id_t   b_id_o,
    input logic      b_valid_o,
    input logic      b_ready_i,
    input axi_id_t   r_id_o,
    input axi_data_t r_data_o,
    input logic      r_last_o,
    input logic      r_valid_o,
    input logic      r_ready_i,
    input logic      cen_o,
    input logic      wen_o
);

    // Number of assertion failures so far
    int unsigned fail_count = 0;

    // R payload held under back-pressure
    r_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o)
                                    && $stable(r_id_o) && $stable(r_last_o))
        else
        begin
            $error("R channel dropped or changed before RREADY");
            fail_count++;
        end

    b_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_id_o))
        else
        begin
            $error("B channel dropped or changed before BREADY");
            fail_count++;
        end

    // Write enable only with chip enable
    wen_in_access: assert property (@(posedge ACLK) disable iff (!ARESETn)
        !(cen_o && !wen_o))
        else
        begin
            $error("WEN low while CEN high");
            fail_count++;
        end

    // Last W beat ends the burst
    wlast_end: assert property (@(posedge ACLK) disable iff (!ARESETn)
        w_valid_i && w_ready_o && w_last_i |=> b_valid_o)
        else
        begin
            $error("WLAST beat not followed by a B response");
            fail_count++;
        end

endmodule

bind axi_mem_bridge axi_mem_bridge_asserts u_asserts (.*);

`default_nettype wire

// ==== tb_axi_mem_bridge.sv ====
// ------------------------------------------------------------
// Directed testbench for the AXI4 to SRAM bridge, with an SRAM
// model, AXI driver tasks, a scoreboard and compare tasks
// ------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_axi_mem_bridge
    import axi_mem_pkg::*;
#(
    parameter int SEED = 32'he6fa
);

    localparam int TIMEOUT = 200;
    localparam int SRAM_AW = 12;

    typedef logic [SRAM_AW-1:0] sram_idx_t;
    typedef enum {WAIT_AW, WAIT_W, WAIT_B, WAIT_AR, WAIT_R} wait_sel_t;

    logic      ACLK;
    logic      ARESETn;
    axi_id_t   aw_id_i;
    axi_addr_t aw_addr_i;
    axi_len_t  aw_len_i;
    logic      aw_valid_i;
    logic      aw_ready_o;
    axi_data_t w_data_i;
    axi_strb_t w_strb_i;
    logic      w_last_i;
    logic      w_valid_i;
    logic      w_ready_o;
    axi_id_t   b_id_o;
    logic      b_valid_o;
    logic      b_ready_i;
    axi_id_t   ar_id_i;
    axi_addr_t ar_addr_i;
    axi_len_t  ar_len_i;
    logic      ar_valid_i;
    logic      ar_ready_o;
    axi_id_t   r_id_o;
    axi_data_t r_data_o;
    logic      r_last_o;
    logic      r_valid_o;
    logic      r_ready_i;
    logic      cen_o;
    logic      wen_o;
    mem_addr_t a_o;
    axi_data_t d_o;
    axi_strb_t be_o;
    axi_data_t q_i = '0;

    axi_data_t sram [0:(1<<SRAM_AW)-1];
    axi_data_t exp_mem [0:(1<<SRAM_AW)-1];
    axi_data_t wdata_buf [0:255];
    axi_strb_t wstrb_buf [0:255];
    integer    seed;
    int        errors;
    int        checks;
    int        timeouts;
    int        assert_fails;

    axi_mem_bridge dut (.*);

    always #5 ACLK = ~ACLK;

    // Reset contents depend on every word address bit
    function automatic axi_data_t initial_word(input int idx);
        return {4'hA, idx[11:0], 4'h5, ~idx[11:0]};
    endfunction

    // ------------------------------------------------------------
    // SRAM model with byte enables, one-cycle read latency
    // ------------------------------------------------------------
    always @(posedge ACLK)
    begin
        if (!ARESETn)
        begin
            for (int i = 0; i < (1 << SRAM_AW); i++)
                sram[i] <= initial_word(i);
        end
        else if (!cen_o)
        begin
            if (!wen_o)
            begin
                for (int b = 0; b < STRB_W; b++)
                begin
                    if (be_o[b])
                        sram[a_o[SRAM_AW-1:0]][8*b +: 8] <= d_o[8*b +: 8];
                end
            end
            else
            begin
                q_i <= sram[a_o[SRAM_AW-1:0]];
            end
        end
    end

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
        checks++;
        if (exp !== act)
        begin
            $display("MISMATCH %s data expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_id(input string name, input axi_id_t exp, input axi_id_t act);
        checks++;
        if (exp !== act)
        begin
            $display("MISMATCH %s id expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act)
        begin
            $display("MISMATCH %s flag expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    function automatic logic wait_signal(input wait_sel_t sel);
        case (sel)
            WAIT_AW: return aw_ready_o;
            WAIT_W:  return w_ready_o;
            WAIT_B:  return b_valid_o;
            WAIT_AR: return ar_ready_o;
            default: return r_valid_o;
        endcase
    endfunction

    // Called on a falling edge, returns just after one
    task automatic wait_until(input wait_sel_t sel, input string what, output int cycles);
        cycles = 0;
        #1;
        while (!wait_signal(sel) && cycles < TIMEOUT)
        begin
            @(negedge ACLK);
            #1;
            cycles++;
        end
        if (!wait_signal(sel))
        begin
            $display("Timeout while waiting for %s", what);
            timeouts++;
        end
    endtask

    function automatic sram_idx_t word_index(input axi_addr_t addr, input int beat);
        return sram_idx_t'(int'(addr >> WORD_LSB) + beat);
    endfunction

    // ------------------------------------------------------------
    // AXI driver tasks
    // ------------------------------------------------------------
    task automatic write_burst(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                               input string name);
        int        cyc;
        sram_idx_t idx;
        aw_id_i    = id;
        aw_addr_i  = addr;
        aw_len_i   = len;
        aw_valid_i = 1'b1;
        wait_until(WAIT_AW, "AW ready", cyc);
        @(negedge ACLK);
        aw_valid_i = 1'b0;
        for (int i = 0; i <= int'(len); i++)
        begin
            w_data_i  = wdata_buf[i];
            w_strb_i  = wstrb_buf[i];
            w_last_i  = (i == int'(len));
            w_valid_i = 1'b1;
            wait_until(WAIT_W, "W ready", cyc);
            // Scoreboard takes only the bytes with their strobe set
            idx = word_index(addr, i);
            for (int b = 0; b < STRB_W; b++)
            begin
                if (wstrb_buf[i][b])
                    exp_mem[idx][8*b +: 8] = wdata_buf[i][8*b +: 8];
            end
            @(negedge ACLK);
        end
        w_valid_i = 1'b0;
        w_last_i  = 1'b0;
        b_ready_i = 1'b1;
        wait_until(WAIT_B, "B valid", cyc);
        if (cyc != 0)
        begin
            $display("%s: B response came %0d cycles late", name, cyc);
            errors++;
        end
        check_id(name, id, b_id_o);
        @(negedge ACLK);
        b_ready_i = 1'b0;
    endtask

    task automatic read_burst(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                              input string name, input logic gaps, input logic check_lat);
        int cyc;
        ar_id_i    = id;
        ar_addr_i  = addr;
        ar_len_i   = len;
        ar_valid_i = 1'b1;
        wait_until(WAIT_AR, "AR ready", cyc);
        @(negedge ACLK);
        ar_valid_i = 1'b0;
        for (int i = 0; i <= int'(len); i++)
        begin
            r_ready_i = !gaps;
            wait_until(WAIT_R, "R valid", cyc);
            // Uncontended: issue, capture, then valid
            if (check_lat && cyc != 2)
            begin
                $display("%s: beat %0d came after %0d cycles instead of 2", name, i, cyc);
                errors++;
            end
            if (gaps)
            begin
                repeat (1 + ($random(seed) & 3)) @(negedge ACLK);
                r_ready_i = 1'b1;
                #1;
            end
            check_data(name, exp_mem[word_index(addr, i)], r_data_o);
            check_id(name, id, r_id_o);
            check_flag(name, (i == int'(len)), r_last_o);
            @(negedge ACLK);
        end
        r_ready_i = 1'b0;
    endtask

    task automatic fill_write_data(input int beats, input logic rand_strb);
        for (int i = 0; i < beats; i++)
        begin
            wdata_buf[i] = $random(seed);
            wstrb_buf[i] = rand_strb ? axi_strb_t'($random(seed)) : '1;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("Test %s finished with %0d errors", name, errors - errs_before);
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic test_reset_state();
        int e0;
        e0 = errors;
        #1;
        check_flag("reset_state", 1'b1, aw_ready_o);
        check_flag("reset_state", 1'b1, ar_ready_o);
        check_flag("reset_state", 1'b0, b_valid_o);
        check_flag("reset_state", 1'b0, r_valid_o);
        check_flag("reset_state", 1'b1, cen_o);
        check_flag("reset_state", 1'b1, wen_o);
        @(negedge ACLK);
        report_test("reset_state", e0);
    endtask

    task automatic test_single_write_read();
        int e0;
        e0 = errors;
        fill_write_data(1, 1'b0);
        write_burst(4'h3, 32'h0000_0020, 8'd0, "single_write_read");
        read_burst(4'h9, 32'h0000_0020, 8'd0, "single_write_read", 1'b0, 1'b1);
        report_test("single_write_read", e0);
    endtask

    task automatic test_burst_strobes();
        int e0;
        e0 = errors;
        fill_write_data(16, 1'b1);
        write_burst(4'hA, 32'h0000_0100, 8'd15, "burst_strobes");
        read_burst(4'hB, 32'h0000_0100, 8'd15, "burst_strobes", 1'b0, 1'b1);
        report_test("burst_strobes", e0);
    endtask

    task automatic test_read_backpressure();
        int e0;
        e0 = errors;
        read_burst(4'h2, 32'h0000_0400, 8'd11, "read_backpressure", 1'b1, 1'b1);
        report_test("read_backpressure", e0);
    endtask

    task automatic test_concurrent();
        int e0;
        e0 = errors;
        fill_write_data(8, 1'b0);
        fork
            write_burst(4'h5, 32'h0000_0800, 8'd7, "concurrent");
            read_burst(4'h6, 32'h0000_0C00, 8'd7, "concurrent", 1'b0, 1'b0);
        join
        read_burst(4'h7, 32'h0000_0800, 8'd7, "concurrent", 1'b0, 1'b1);
        report_test("concurrent", e0);
    endtask

    initial
    begin
        seed       = SEED;
        errors     = 0;
        checks     = 0;
        timeouts   = 0;
        ACLK       = 1'b0;
        ARESETn    = 1'b0;
        aw_id_i    = '0;
        aw_addr_i  = '0;
        aw_len_i   = '0;
        aw_valid_i = 1'b0;
        w_data_i   = '0;
        w_strb_i   = '0;
        w_last_i   = 1'b0;
        w_valid_i  = 1'b0;
        b_ready_i  = 1'b0;
        ar_id_i    = '0;
        ar_addr_i  = '0;
        ar_len_i   = '0;
        ar_valid_i = 1'b0;
        r_ready_i  = 1'b0;
        for (int i = 0; i < (1 << SRAM_AW); i++)
            exp_mem[i] = initial_word(i);
        repeat (4) @(posedge ACLK);
        @(negedge ACLK);
        ARESETn = 1'b1;

        test_reset_state();
        test_single_write_read();
        test_burst_strobes();
        test_read_backpressure();
        test_concurrent();

        assert_fails = int'(dut.u_asserts.fail_count);
        $display("Checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, assert_fails);
        if (errors == 0 && timeouts == 0 && assert_fails == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== axi_mem_bridge.f ====
axi_mem_pkg.sv
mem_req_if.sv
axi_write_engine.sv
axi_read_engine.sv
mem_port_arbiter.sv
axi_mem_bridge.sv
axi_mem_bridge_asserts.sv
tb_axi_mem_bridge.sv

// ==== Makefile ====
# Verilator build and run for the AXI4 to SRAM bridge

TOP       ?= tb_axi_mem_bridge
FLIST     ?= axi_mem_bridge.f
LOG       ?= sim.log
SEED      ?= 59130
OBJ       ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) -Mdir $(OBJ) -f $(FLIST)

run: compile
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ) $(LOG)
